/* aes_core.f */
hdl/aes_types_pkg.sv
hdl/aes_gf_pkg.sv
hdl/aes_control.sv
hdl/aes_key_schedule.sv
hdl/aes_round_datapath.sv
hdl/aes_core.sv
tb/aes_core_asserts.sv
tb/aes_core_tb.sv

/* hdl/aes_control.sv */
module aes_control
    import aes_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  logic       out_ready,
    output logic       in_ready,
    output logic       out_valid,
    output round_cmd_t cmd,
    output round_idx_t round
);

    logic step_q;
    logic last_q;
    logic accept;

    assign accept = in_valid && in_ready;

    // the load happens on the accepting edge itself, so it follows the handshake
    assign cmd.load = accept;
    assign cmd.step = step_q;
    assign cmd.last = last_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            in_ready  <= 1'b1;
            out_valid <= 1'b0;
            step_q    <= 1'b0;
            last_q    <= 1'b0;
            round     <= '0;
        end
        else if (accept)
        begin
            in_ready <= 1'b0;
            step_q   <= 1'b1;
            last_q   <= 1'b0;
            round    <= round_idx_t'(1);
        end
        else if (step_q)
        begin
            if (last_q)
            begin
                // round 10 completes on this edge and the result is held
                step_q    <= 1'b0;
                last_q    <= 1'b0;
                out_valid <= 1'b1;
                round     <= '0;
            end
            else
            begin
                round  <= round + round_idx_t'(1);
                last_q <= (round == round_idx_t'(num_rounds - 1));
            end
        end
        else if (out_valid && out_ready)
        begin
            out_valid <= 1'b0;
            in_ready  <= 1'b1;
        end
    end

endmodule

/* hdl/aes_core.sv */
module aes_core
    import aes_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  aes_block_u in_data,
    input  aes_block_u in_key,
    output logic       out_valid,
    input  logic       out_ready,
    output aes_block_u out_data
);

    round_cmd_t cmd;
    round_idx_t round;
    aes_block_u round_key;

    aes_control u_control (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .cmd       (cmd),
        .round     (round)
    );

    aes_key_schedule u_key_schedule (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .round     (round),
        .in_key    (in_key),
        .round_key (round_key)
    );

    // the state register holds the result while the output waits
    aes_round_datapath u_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .in_data   (in_data),
        .in_key    (in_key),
        .round_key (round_key),
        .state     (out_data)
    );

endmodule

/* hdl/aes_gf_pkg.sv */
package aes_gf_pkg;

    // low byte of the AES reduction polynomial x^8 + x^4 + x^3 + x + 1
    localparam logic [7:0] aes_poly = 8'h1b;

    // ~~~~~~~~~~~~~~~~~~~~
    // field arithmetic
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? aes_poly : 8'h00);
    endfunction

    // shift-and-add multiply, one xtime per bit of b
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] sh;
        acc = 8'h00;
        sh  = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ sh;
            sh = xtime(sh);
        end
        return acc;
    endfunction

    // inverse as a^254, the product of a^2, a^4 ... a^128
    // zero maps to zero as the S-box definition requires
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] acc;
        logic [7:0] sq;
        acc = 8'h01;
        sq  = a;
        for (int i = 1; i < 8; i++)
        begin
            sq  = gf_mul(sq, sq);
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    // forward S-box, inverse followed by the affine map
    function automatic logic [7:0] sbox(input logic [7:0] a);
        logic [7:0] b;
        b = gf_inv(a);
        return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
                 ^ {b[3:0], b[7:4]} ^ 8'h63;
    endfunction

    // round constant for rounds 1 to 10, doubling from 01
    function automatic logic [7:0] rcon(input logic [3:0] r);
        logic [7:0] rc;
        rc = 8'h01;
        for (int i = 2; i <= 10; i++)
        begin
            if (i <= r)
                rc = xtime(rc);
        end
        return rc;
    endfunction

endpackage

/* hdl/aes_key_schedule.sv */
module aes_key_schedule
    import aes_types_pkg::*;
    import aes_gf_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  round_cmd_t cmd,
    input  round_idx_t round,
    input  aes_block_u in_key,
    output aes_block_u round_key
);

    aes_block_u key_q;
    aes_block_u next_key;
    logic [31:0] rot_word;
    logic [31:0] sub_word;

    // ~~~~~~~~~~~~~~~~~~~~
    // next key expansion
    // ~~~~~~~~~~~~~~~~~~~~

    // RotWord moves the top byte of the last column to the bottom
    assign rot_word = {key_q.words[3][23:0], key_q.words[3][31:24]};

    always_comb
    begin
        for (int i = 0; i < 4; i++)
            sub_word[i*8 +: 8] = sbox(rot_word[i*8 +: 8]);
    end

    // each later column chains on the one just formed
    always_comb
    begin
        next_key.words[0] = key_q.words[0] ^ sub_word ^ {rcon(round), 24'h000000};
        for (int c = 1; c < 4; c++)
            next_key.words[c] = key_q.words[c] ^ next_key.words[c-1];
    end

    // the expanded key serves the round executing in this same cycle
    assign round_key = next_key;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            key_q <= '0;
        else if (cmd.load)
            key_q <= in_key;
        else if (cmd.step)
            key_q <= next_key;
    end

endmodule

/* hdl/aes_round_datapath.sv */
module aes_round_datapath
    import aes_types_pkg::*;
    import aes_gf_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  round_cmd_t cmd,
    input  aes_block_u in_data,
    input  aes_block_u in_key,
    input  aes_block_u round_key,
    output aes_block_u state
);

    aes_block_u sub_bytes;
    aes_block_u shift_rows;
    aes_block_u mix_cols;
    aes_block_u round_in;
    aes_block_u round_out;

    // one column times the fixed MixColumns matrix
    // each output byte is its input, the column sum, and xtime of a neighbour pair
    function automatic logic [31:0] mix_column(input logic [31:0] col);
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        logic [7:0] t;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        t  = a0 ^ a1 ^ a2 ^ a3;
        return {a0 ^ t ^ xtime(a0 ^ a1),
                a1 ^ t ^ xtime(a1 ^ a2),
                a2 ^ t ^ xtime(a2 ^ a3),
                a3 ^ t ^ xtime(a3 ^ a0)};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // round logic
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        for (int i = 0; i < 16; i++)
            sub_bytes.bytes[i] = sbox(state.bytes[i]);
    end

    // byte c*4+r sits in row r of column c, and row r rotates left by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                shift_rows.bytes[c*4 + r] = sub_bytes.bytes[((c + r) % 4)*4 + r];
        end
    end

    always_comb
    begin
        for (int c = 0; c < 4; c++)
            mix_cols.words[c] = mix_column(shift_rows.words[c]);
    end

    // the final round skips MixColumns
    assign round_in  = cmd.last ? shift_rows : mix_cols;
    assign round_out = round_in ^ round_key;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= '0;
        else if (cmd.load)
            state <= in_data ^ in_key;
        else if (cmd.step)
            state <= round_out;
    end

endmodule

/* hdl/aes_types_pkg.sv */
package aes_types_pkg;

    localparam int block_bits = 128;
    localparam int num_rounds = 10;

    // round 0 is the initial key load, 1 to 10 are the executed rounds
    typedef logic [3:0] round_idx_t;

    // one 128-bit block seen as column words or as bytes
    // index 0 is the most significant in both views, so word 0 holds bytes 0 to 3
    typedef union packed {
        logic [0:block_bits/32-1][31:0] words;
        logic [0:block_bits/8-1][7:0]   bytes;
    } aes_block_u;

    // command from the controller to the key schedule and the datapath
    typedef struct packed {
        logic load;
        logic step;
        logic last;
    } round_cmd_t;

endpackage

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module aes_core_tb -f aes_core.f -o aes_core_sim
./obj_dir/aes_core_sim > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"

/* tb/aes_core_asserts.sv */
module aes_core_asserts
    import aes_types_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       in_valid,
    input logic       in_ready,
    input aes_block_u in_data,
    input aes_block_u in_key,
    input logic       out_valid,
    input logic       out_ready,
    input aes_block_u out_data
);

    // ~~~~~~~~~~~~~~~~~~~~
    // handshake rules
    // ~~~~~~~~~~~~~~~~~~~~

    // a pending input keeps its valid and its data until it is taken
    assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_data) && $stable(in_key))
        else $error("input valid dropped or input data changed before the transfer");

    // a stalled result stays on the output unchanged
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("output valid dropped or output data changed during a stall");

    assert property (@(posedge clk) disable iff (!rst_n)
        !(in_ready && out_valid))
        else $error("in_ready and out_valid are high together");

    // ~~~~~~~~~~~~~~~~~~~~
    // latency
    // ~~~~~~~~~~~~~~~~~~~~

    // out_valid is set on the tenth edge after the accept, seen one sample later
    assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && in_ready |-> ##11 $rose(out_valid))
        else $error("out_valid did not rise ten cycles after an input accept");

endmodule

bind aes_core aes_core_asserts u_asserts (.*);

/* tb/aes_core_tb.sv */
module aes_core_tb
    import aes_types_pkg::*;
;

    localparam int clk_period     = 40;
    localparam int reset_cycles   = 4;
    localparam int max_stall      = 5;
    localparam int num_vectors    = 6;
    localparam int timeout_cycles =
        num_vectors * (num_rounds + max_stall + 4) + reset_cycles;

    typedef struct packed {
        aes_block_u key;
        aes_block_u pt;
        aes_block_u ct;
    } vector_t;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic       in_ready;
    aes_block_u in_data;
    aes_block_u in_key;
    logic       out_valid;
    logic       out_ready;
    aes_block_u out_data;

    vector_t vectors [0:num_vectors-1];
    integer  seed;
    int      block_errors;
    int      flag_errors;

    aes_core uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .in_key    (in_key),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic check_block(input string name, input aes_block_u got, input aes_block_u exp);
        if (got !== exp)
        begin
            block_errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            flag_errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // one block through the core, entered and left at 2 units past a rising edge
    task automatic run_vector(input vector_t v, input vector_t next_v, input logic has_next);
        int   stalls;
        int   rnd;
        logic go;
        stalls   = 0;
        in_data  = v.pt;
        in_key   = v.key;
        in_valid = 1'b1;
        while (!in_ready)
        begin
            @(posedge clk);
            #2;
        end
        // the next edge takes the block
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        for (int n = 1; n <= num_rounds; n++)
        begin
            @(posedge clk);
            #2;
            check_flag("out_valid", out_valid, n == num_rounds);
            check_flag("in_ready", in_ready, 1'b0);
        end
        check_block("out_data", out_data, v.ct);
        // the next block waits at the input while this result is still held
        if (has_next)
        begin
            in_data  = next_v.pt;
            in_key   = next_v.key;
            in_valid = 1'b1;
        end
        // random back-pressure, never longer than max_stall cycles
        do
        begin
            rnd       = $random(seed);
            go        = rnd[0] || (stalls == max_stall);
            out_ready = go;
            @(posedge clk);
            #2;
            out_ready = 1'b0;
            if (!go)
            begin
                stalls++;
                check_flag("out_valid", out_valid, 1'b1);
                check_flag("in_ready", in_ready, 1'b0);
                check_block("out_data", out_data, v.ct);
            end
        end
        while (!go);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~

    initial
    begin
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        in_key       = '0;
        out_ready    = 1'b0;
        seed         = 32'h2114_1271;
        block_errors = 0;
        flag_errors  = 0;

        // each row is key, plaintext, expected ciphertext from published vectors
        // neighbouring rows use different keys so the key register must reload
        vectors[0] = {128'h000102030405060708090a0b0c0d0e0f,
                      128'h00112233445566778899aabbccddeeff,
                      128'h69c4e0d86a7b0430d8cdb78070b4c55a};
        vectors[1] = {128'h2b7e151628aed2a6abf7158809cf4f3c,
                      128'h3243f6a8885a308d313198a2e0370734,
                      128'h3925841d02dc09fbdc118597196a0b32};
        vectors[2] = {128'h00000000000000000000000000000000,
                      128'h00000000000000000000000000000000,
                      128'h66e94bd4ef8a2c3b884cfa59ca342b2e};
        vectors[3] = {128'h2b7e151628aed2a6abf7158809cf4f3c,
                      128'h00000000000000000000000000000000,
                      128'h7df76b0c1ab899b33e42f047b91b546f};
        vectors[4] = {128'h00000000000000000000000000000000,
                      128'h80000000000000000000000000000000,
                      128'h3ad78e726c1ec02b7ebfe92b23d9ec34};
        vectors[5] = {128'h2b7e151628aed2a6abf7158809cf4f3c,
                      128'h6bc1bee22e409f96e93d7e117393172a,
                      128'h3ad77bb40d7a3660a89ecaf32466ef97};

        repeat (reset_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);

        for (int i = 0; i < num_vectors; i++)
            run_vector(vectors[i], vectors[(i + 1) % num_vectors], i < num_vectors - 1);

        $display("checks done: %0d data errors, %0d handshake errors",
                 block_errors, flag_errors);
        if (block_errors == 0 && flag_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    // the budget covers every row with its longest stall plus the reset
    initial
    begin
        #(timeout_cycles * clk_period);
        $display("run timed out after %0d cycles without finishing all rows", timeout_cycles);
        $display("Something failed");
        $finish;
    end

endmodule
